//--- Makefile
# Verilator flow for the SoC data fabric

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TB_TOP    ?= tb_soc_data_fabric
RTL_TOP   ?= soc_data_fabric
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_STR  ?= STATUS: PASS

SIM_BIN = $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TB_TOP)

# Pass only if the testbench printed the pass line
sim: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_STR)"

clean:
	rm -rf $(BUILD_DIR)

//--- design/clint_pkg.sv
package clint_pkg;

    // ----------------------------------------
    // Register word offsets
    // ----------------------------------------
    // Software interrupt pending, bit 0 only
    localparam int unsigned CLINT_MSIP     = 0;

    // 64-bit free-running time, low word first
    localparam int unsigned CLINT_MTIME_LO = 2;
    localparam int unsigned CLINT_MTIME_HI = 3;

    // 64-bit timer compare value
    localparam int unsigned CLINT_CMP_LO   = 4;
    localparam int unsigned CLINT_CMP_HI   = 5;

    // ----------------------------------------
    // Time base and reset values
    // ----------------------------------------
    localparam int MTIME_W     = 64;

    // Clock cycles per mtime tick
    localparam int MTIME_DIV   = 8;
    localparam int MTIME_DIV_W = $clog2(MTIME_DIV);

    // Compare starts at the maximum so no timer interrupt fires after reset
    localparam logic [MTIME_W-1:0] CMP_RESET = {MTIME_W{1'b1}};

endpackage

//--- design/clint_timer.sv
`timescale 1ns/100ps

module clint_timer import mem_map_pkg::*, clint_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    target_bus_if.target bus,
    output logic         tmr_irq_o,
    output logic         sft_irq_o
);

    logic [31:0]            word_idx;
    logic                   wr;
    logic                   tick;

    logic                   msip_q;
    logic [MTIME_DIV_W-1:0] div_q;
    logic [MTIME_W-1:0]     mtime_q;
    logic [MTIME_W-1:0]     cmp_q;

    logic [DATA_W-1:0]      rdata_q;
    logic                   ready_q;
    logic                   tmr_irq_q;
    logic                   sft_irq_q;

    // Merge write data into an existing word under byte enables
    function automatic logic [DATA_W-1:0] merge_be(
        input logic [DATA_W-1:0] old_w,
        input logic [DATA_W-1:0] new_w,
        input logic [BE_W-1:0]   be
    );
        logic [DATA_W-1:0] res;
        res = old_w;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // Zero-extended index so it compares against the offsets directly
    assign word_idx = 32'(bus.idx);
    assign wr       = bus.en && bus.we;

    // Last cycle of each time-base period
    assign tick = (div_q == MTIME_DIV_W'(MTIME_DIV - 1));

    // ----------------------------------------
    // Register state
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            msip_q  <= 1'b0;
            div_q   <= '0;
            mtime_q <= '0;
            cmp_q   <= CMP_RESET;
        end else begin
            // Prescaler runs regardless of bus writes
            div_q <= tick ? '0 : div_q + MTIME_DIV_W'(1);

            if (wr && word_idx == CLINT_MSIP && bus.be[0]) begin
                msip_q <= bus.wdata[0];
            end

            // A bus write to mtime wins over the tick
            if (wr && word_idx == CLINT_MTIME_LO) begin
                mtime_q[DATA_W-1:0] <= merge_be(mtime_q[DATA_W-1:0], bus.wdata, bus.be);
            end else if (wr && word_idx == CLINT_MTIME_HI) begin
                mtime_q[MTIME_W-1:DATA_W] <=
                    merge_be(mtime_q[MTIME_W-1:DATA_W], bus.wdata, bus.be);
            end else if (tick) begin
                mtime_q <= mtime_q + MTIME_W'(1);
            end

            if (wr && word_idx == CLINT_CMP_LO) begin
                cmp_q[DATA_W-1:0] <= merge_be(cmp_q[DATA_W-1:0], bus.wdata, bus.be);
            end
            if (wr && word_idx == CLINT_CMP_HI) begin
                cmp_q[MTIME_W-1:DATA_W] <= merge_be(cmp_q[MTIME_W-1:DATA_W], bus.wdata, bus.be);
            end
        end
    end

    // ----------------------------------------
    // Read response one cycle after en
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (bus.en) begin
            case (word_idx)
                CLINT_MSIP:     rdata_q <= {{(DATA_W-1){1'b0}}, msip_q};
                CLINT_MTIME_LO: rdata_q <= mtime_q[DATA_W-1:0];
                CLINT_MTIME_HI: rdata_q <= mtime_q[MTIME_W-1:DATA_W];
                CLINT_CMP_LO:   rdata_q <= cmp_q[DATA_W-1:0];
                CLINT_CMP_HI:   rdata_q <= cmp_q[MTIME_W-1:DATA_W];
                // Unmapped words read as zero
                default:        rdata_q <= '0;
            endcase
        end
    end

    // Ready pulse and registered interrupt outputs
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ready_q   <= 1'b0;
            tmr_irq_q <= 1'b0;
            sft_irq_q <= 1'b0;
        end else begin
            ready_q   <= bus.en;
            tmr_irq_q <= (mtime_q >= cmp_q);
            sft_irq_q <= msip_q;
        end
    end

    assign bus.rdata = rdata_q;
    assign bus.ready = ready_q;
    assign tmr_irq_o = tmr_irq_q;
    assign sft_irq_o = sft_irq_q;

    // Time moves by at most one tick per cycle unless the bus writes it
    a_mtime_step: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !$past(wr && (word_idx == CLINT_MTIME_LO || word_idx == CLINT_MTIME_HI))
            |-> (mtime_q - $past(mtime_q)) <= MTIME_W'(1)
    ) else $error("clint_timer: mtime jumped without a bus write");

endmodule

//--- design/data_bus_router.sv
`timescale 1ns/100ps

module data_bus_router import mem_map_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,

    // Processor data bus
    input  logic            d_strobe_i,
    input  logic            d_rw_i,
    input  logic [ADDR_W-1:0] d_addr_i,
    input  logic [BE_W-1:0] d_be_i,
    input  logic [DATA_W-1:0] d_wdata_i,
    output logic [DATA_W-1:0] d_rdata_o,
    output logic            d_ready_o,

    // External uncached port
    output logic            dev_strobe_o,
    output logic            dev_rw_o,
    output logic [ADDR_W-1:0] dev_addr_o,
    output logic [BE_W-1:0] dev_be_o,
    output logic [DATA_W-1:0] dev_wdata_o,
    input  logic            dev_ready_i,
    input  logic [DATA_W-1:0] dev_rdata_i,

    // On-chip targets
    target_bus_if.initiator tcm_bus,
    target_bus_if.initiator clint_bus
);

    logic [SEG_MSB-SEG_LSB:0] seg;
    target_sel_t              sel;
    target_sel_t              sel_q;
    logic                     ext_hit;
    logic                     pend_q;
    logic                     resp_ready;

    // ----------------------------------------
    // Segment decode
    // ----------------------------------------
    assign seg = d_addr_i[SEG_MSB:SEG_LSB];

    always_comb begin
        if (seg == SEG_TCM) begin
            sel = TGT_TCM;
        end else if (seg == SEG_CLINT) begin
            sel = TGT_CLINT;
        end else begin
            // All remaining segments share the external port
            sel = TGT_EXT;
        end
    end

    assign ext_hit = (sel == TGT_EXT);

    // On-chip requests, only the selected target sees en
    assign tcm_bus.en      = d_strobe_i && (sel == TGT_TCM);
    assign tcm_bus.we      = d_rw_i;
    assign tcm_bus.be      = d_be_i;
    assign tcm_bus.idx     = d_addr_i[TGT_IDX_W+1:2];
    assign tcm_bus.wdata   = d_wdata_i;

    assign clint_bus.en    = d_strobe_i && (sel == TGT_CLINT);
    assign clint_bus.we    = d_rw_i;
    assign clint_bus.be    = d_be_i;
    assign clint_bus.idx   = d_addr_i[TGT_IDX_W+1:2];
    assign clint_bus.wdata = d_wdata_i;

    // External port, zeroed outside its own segments
    assign dev_strobe_o = d_strobe_i && ext_hit;
    assign dev_rw_o     = d_rw_i && ext_hit;
    assign dev_addr_o   = ext_hit ? d_addr_i : '0;
    assign dev_be_o     = ext_hit ? d_be_i : '0;
    assign dev_wdata_o  = ext_hit ? d_wdata_i : '0;

    // ----------------------------------------
    // Request tracking
    // ----------------------------------------
    // Select captured per strobe, so a slow external reply still steers right
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sel_q  <= TGT_TCM;
            pend_q <= 1'b0;
        end else begin
            if (d_strobe_i) begin
                sel_q  <= sel;
                pend_q <= 1'b1;
            end else if (d_ready_o) begin
                pend_q <= 1'b0;
            end
        end
    end

    // Response mux on the registered select
    always_comb begin
        case (sel_q)
            TGT_TCM: begin
                d_rdata_o  = tcm_bus.rdata;
                resp_ready = tcm_bus.ready;
            end
            TGT_CLINT: begin
                d_rdata_o  = clint_bus.rdata;
                resp_ready = clint_bus.ready;
            end
            default: begin
                d_rdata_o  = dev_rdata_i;
                resp_ready = dev_ready_i;
            end
        endcase
    end

    // Stray target pulses with nothing outstanding are dropped
    assign d_ready_o = pend_q && resp_ready;

    a_one_target: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({tcm_bus.en, clint_bus.en, dev_strobe_o})
    ) else $error("data_bus_router: more than one target strobed");

    // New strobe only once the previous request has completed
    a_no_overlap: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        d_strobe_i && pend_q |-> d_ready_o
    ) else $error("data_bus_router: strobe while a request is outstanding");

endmodule

//--- design/mem_map_pkg.sv
package mem_map_pkg;

    // ----------------------------------------
    // Bus widths
    // ----------------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = DATA_W / 8;

    // ----------------------------------------
    // Segment decode on the top address nibble
    // ----------------------------------------
    localparam int SEG_MSB = 31;
    localparam int SEG_LSB = 28;

    localparam logic [SEG_MSB-SEG_LSB:0] SEG_TCM   = 4'h0;
    localparam logic [SEG_MSB-SEG_LSB:0] SEG_CLINT = 4'hF;

    // On-chip word memory
    localparam int TCM_WORDS = 1024;
    localparam int TCM_IDX_W = $clog2(TCM_WORDS);

    // Word index sent to on-chip targets, taken from addr[TGT_IDX_W+1:2]
    localparam int TGT_IDX_W = 10;

    // Target select, registered at request time to steer the response
    typedef enum logic [1:0] {
        TGT_TCM,
        TGT_CLINT,
        TGT_EXT
    } target_sel_t;

endpackage

//--- design/soc_data_fabric.sv
`timescale 1ns/100ps

module soc_data_fabric import mem_map_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,

    // Processor data bus
    input  logic              d_strobe_i,
    input  logic              d_rw_i,
    input  logic [ADDR_W-1:0] d_addr_i,
    input  logic [BE_W-1:0]   d_be_i,
    input  logic [DATA_W-1:0] d_wdata_i,
    output logic [DATA_W-1:0] d_rdata_o,
    output logic              d_ready_o,

    // External uncached port
    output logic              dev_strobe_o,
    output logic              dev_rw_o,
    output logic [ADDR_W-1:0] dev_addr_o,
    output logic [BE_W-1:0]   dev_be_o,
    output logic [DATA_W-1:0] dev_wdata_o,
    input  logic              dev_ready_i,
    input  logic [DATA_W-1:0] dev_rdata_i,

    // Interrupts from the CLINT
    output logic              tmr_irq_o,
    output logic              sft_irq_o
);

    // ----------------------------------------
    // Router to on-chip target links
    // ----------------------------------------
    target_bus_if tcm_bus ();
    target_bus_if clint_bus ();

    data_bus_router i_data_bus_router (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .d_strobe_i   (d_strobe_i),
        .d_rw_i       (d_rw_i),
        .d_addr_i     (d_addr_i),
        .d_be_i       (d_be_i),
        .d_wdata_i    (d_wdata_i),
        .d_rdata_o    (d_rdata_o),
        .d_ready_o    (d_ready_o),
        .dev_strobe_o (dev_strobe_o),
        .dev_rw_o     (dev_rw_o),
        .dev_addr_o   (dev_addr_o),
        .dev_be_o     (dev_be_o),
        .dev_wdata_o  (dev_wdata_o),
        .dev_ready_i  (dev_ready_i),
        .dev_rdata_i  (dev_rdata_i),
        .tcm_bus      (tcm_bus.initiator),
        .clint_bus    (clint_bus.initiator)
    );

    // Segment 0x0
    tcm_sram i_tcm_sram (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bus     (tcm_bus.target)
    );

    // Segment 0xF
    clint_timer i_clint_timer (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .bus       (clint_bus.target),
        .tmr_irq_o (tmr_irq_o),
        .sft_irq_o (sft_irq_o)
    );

endmodule

//--- design/target_bus_if.sv
`timescale 1ns/100ps

interface target_bus_if import mem_map_pkg::*; ();

    // Request, driven by the router
    logic                 en;
    logic                 we;
    logic [BE_W-1:0]      be;
    logic [TGT_IDX_W-1:0] idx;
    logic [DATA_W-1:0]    wdata;

    // Response, one cycle after en
    logic [DATA_W-1:0]    rdata;
    logic                 ready;

    modport initiator (
        output en,
        output we,
        output be,
        output idx,
        output wdata,
        input  rdata,
        input  ready
    );

    modport target (
        input  en,
        input  we,
        input  be,
        input  idx,
        input  wdata,
        output rdata,
        output ready
    );

endinterface

//--- design/tcm_sram.sv
`timescale 1ns/100ps

module tcm_sram import mem_map_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    target_bus_if.target bus
);

    // Word storage without reset
    logic [DATA_W-1:0]    mem [TCM_WORDS];

    logic [TCM_IDX_W-1:0] addr;
    logic [DATA_W-1:0]    rdata_q;
    logic                 ready_q;

    // Low index bits select the word
    assign addr = bus.idx[TCM_IDX_W-1:0];

    // ----------------------------------------
    // Byte-enabled write port
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (bus.en && bus.we) begin
            for (int b = 0; b < BE_W; b++) begin
                if (bus.be[b]) begin
                    mem[addr][b*8 +: 8] <= bus.wdata[b*8 +: 8];
                end
            end
        end
    end

    // Registered read returns old data on a write cycle
    always_ff @(posedge clk_i) begin
        if (bus.en) begin
            rdata_q <= mem[addr];
        end
    end

    // Ready pulse one cycle after each strobe
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= bus.en;
        end
    end

    assign bus.rdata = rdata_q;
    assign bus.ready = ready_q;

    // Every request field is driven whenever the target is strobed
    a_req_known: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        bus.en |-> !$isunknown({bus.we, bus.be, bus.idx})
    ) else $error("tcm_sram: en with an unknown request field");

endmodule

//--- filelist.f
design/mem_map_pkg.sv
design/clint_pkg.sv
design/target_bus_if.sv
design/tcm_sram.sv
design/clint_timer.sv
design/data_bus_router.sv
design/soc_data_fabric.sv
verif/tb_soc_data_fabric.sv

//--- verif/tb_soc_data_fabric.sv
`timescale 1ns/100ps

module tb_soc_data_fabric import mem_map_pkg::*, clint_pkg::*; ();

    localparam int unsigned SEED = 32'h5e4574f7;

    // Test sizes
    localparam int TCM_WIN   = 64;
    localparam int TCM_WRS   = 64;
    localparam int EXT_COUNT = 32;
    localparam int MIX_COUNT = 96;

    // Estimated length of all tests together
    localparam int TEST_CYCLES = 2000;
    // Run limit at twice the test length
    localparam int TIMEOUT_CYC = 2 * TEST_CYCLES;

    // Timer interrupt deadline after mtime is cleared
    localparam int IRQ_LIMIT = 20 * MTIME_DIV + 4;

    logic              clk_i = 1'b0;
    logic              rst_n_i;
    logic              d_strobe_i;
    logic              d_rw_i;
    logic [ADDR_W-1:0] d_addr_i;
    logic [BE_W-1:0]   d_be_i;
    logic [DATA_W-1:0] d_wdata_i;
    logic [DATA_W-1:0] d_rdata_o;
    logic              d_ready_o;
    logic              dev_strobe_o;
    logic              dev_rw_o;
    logic [ADDR_W-1:0] dev_addr_o;
    logic [BE_W-1:0]   dev_be_o;
    logic [DATA_W-1:0] dev_wdata_o;
    logic              dev_ready_i;
    logic [DATA_W-1:0] dev_rdata_i;
    logic              tmr_irq_o;
    logic              sft_irq_o;

    // Reference models of the on-chip targets
    logic [DATA_W-1:0] tcm_m [TCM_WORDS];
    logic              msip_m = 1'b0;
    logic [63:0]       cmp_m  = CMP_RESET;

    // Expected responses in issue order
    logic [DATA_W-1:0] exp_q [$];
    bit                chk_q [$];

    // Last request for comparison against the external port
    logic [ADDR_W-1:0] req_addr;
    logic              req_rw;
    logic [BE_W-1:0]   req_be;
    logic [DATA_W-1:0] req_wdata;
    int                req_delay;

    int err_cnt       = 0;
    int chk_cnt       = 0;
    int test_err_base = 0;
    int cycle_cnt     = 0;

    always #5 clk_i = ~clk_i;

    soc_data_fabric i_soc_data_fabric (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .d_strobe_i   (d_strobe_i),
        .d_rw_i       (d_rw_i),
        .d_addr_i     (d_addr_i),
        .d_be_i       (d_be_i),
        .d_wdata_i    (d_wdata_i),
        .d_rdata_o    (d_rdata_o),
        .d_ready_o    (d_ready_o),
        .dev_strobe_o (dev_strobe_o),
        .dev_rw_o     (dev_rw_o),
        .dev_addr_o   (dev_addr_o),
        .dev_be_o     (dev_be_o),
        .dev_wdata_o  (dev_wdata_o),
        .dev_ready_i  (dev_ready_i),
        .dev_rdata_i  (dev_rdata_i),
        .tmr_irq_o    (tmr_irq_o),
        .sft_irq_o    (sft_irq_o)
    );

    // ----------------------------------------
    // Address helpers and reference models
    // ----------------------------------------
    // Random bits between segment and index are ignored by the TCM
    function automatic logic [ADDR_W-1:0] tcm_addr(input int idx);
        logic [15:0] mid;
        mid = 16'($urandom);
        return {SEG_TCM, mid, TGT_IDX_W'(idx), 2'b00};
    endfunction

    function automatic logic [ADDR_W-1:0] clint_addr(input int unsigned w);
        return {SEG_CLINT, 16'h0000, TGT_IDX_W'(w), 2'b00};
    endfunction

    // Any segment other than 0x0 and 0xF
    function automatic logic [ADDR_W-1:0] ext_addr();
        logic [3:0]  seg;
        logic [27:0] low;
        seg = 4'($urandom_range(1, 14));
        low = 28'($urandom);
        return {seg, low};
    endfunction

    // Responder data derived from the address alone
    function automatic logic [DATA_W-1:0] ext_value(input logic [ADDR_W-1:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'hc3a5_5a3c;
    endfunction

    // TCM fill word in which every address bit takes part
    function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[7:0], addr[31:8]};
    endfunction

    // mtime moves on its own so its reads are checked by trend only
    function automatic bit predictable(input logic [ADDR_W-1:0] addr);
        int unsigned w;
        w = 32'(addr[TGT_IDX_W+1:2]);
        if (addr[SEG_MSB:SEG_LSB] != SEG_CLINT) begin
            return 1'b1;
        end
        return !(w == CLINT_MTIME_LO || w == CLINT_MTIME_HI);
    endfunction

    // Expected read data from the models
    function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
        logic [TCM_IDX_W-1:0] i;
        int unsigned          w;
        i = addr[TCM_IDX_W+1:2];
        w = 32'(addr[TGT_IDX_W+1:2]);
        if (addr[SEG_MSB:SEG_LSB] == SEG_TCM) begin
            return tcm_m[i];
        end else if (addr[SEG_MSB:SEG_LSB] == SEG_CLINT) begin
            if (w == CLINT_MSIP) begin
                return {31'b0, msip_m};
            end else if (w == CLINT_CMP_LO) begin
                return cmp_m[31:0];
            end else if (w == CLINT_CMP_HI) begin
                return cmp_m[63:32];
            end
            return '0;
        end
        return ext_value(addr);
    endfunction

    // Apply a write to the models under byte enables
    function automatic void model_write(input logic [ADDR_W-1:0] addr,
                                        input logic [BE_W-1:0]   be,
                                        input logic [DATA_W-1:0] wdata);
        logic [TCM_IDX_W-1:0] i;
        int unsigned          w;
        i = addr[TCM_IDX_W+1:2];
        w = 32'(addr[TGT_IDX_W+1:2]);
        for (int b = 0; b < BE_W; b++) begin
            if (be[b] && addr[SEG_MSB:SEG_LSB] == SEG_TCM) begin
                tcm_m[i][b*8 +: 8] = wdata[b*8 +: 8];
            end else if (be[b] && addr[SEG_MSB:SEG_LSB] == SEG_CLINT) begin
                if (w == CLINT_MSIP && b == 0) begin
                    msip_m = wdata[0];
                end
                if (w == CLINT_CMP_LO) begin
                    cmp_m[b*8 +: 8] = wdata[b*8 +: 8];
                end
                if (w == CLINT_CMP_HI) begin
                    cmp_m[32 + b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
        end
    endfunction

    // ----------------------------------------
    // Checks and reporting
    // ----------------------------------------
    task automatic check_value(input string name, input logic [DATA_W-1:0] exp_v,
                               input logic [DATA_W-1:0] act_v);
        chk_cnt++;
        assert (act_v === exp_v) else begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp_v, act_v);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp_v, input logic act_v);
        chk_cnt++;
        assert (act_v === exp_v) else begin
            $display("[ERROR] %0t %s expected %b got %b", $time, name, exp_v, act_v);
            err_cnt++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        chk_cnt++;
        assert (cond) else begin
            $display("Failure at %0t: %s", $time, what);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name);
        $display("Test %s done with %0d errors", name, err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    // One bus transfer that returns at the negedge of the ready cycle
    task automatic bus_access(input logic rw, input logic [ADDR_W-1:0] addr,
                              input logic [BE_W-1:0] be, input logic [DATA_W-1:0] wdata,
                              output logic [DATA_W-1:0] rdata);
        int  lat;
        bit  on_chip;
        on_chip = addr[SEG_MSB:SEG_LSB] == SEG_TCM || addr[SEG_MSB:SEG_LSB] == SEG_CLINT;
        exp_q.push_back(expected_read(addr));
        chk_q.push_back(!rw && predictable(addr));
        if (rw) begin
            model_write(addr, be, wdata);
        end
        req_addr  = addr;
        req_rw    = rw;
        req_be    = be;
        req_wdata = wdata;
        req_delay = int'($urandom_range(1, 4));
        @(posedge clk_i);
        d_strobe_i <= 1'b1;
        d_rw_i     <= rw;
        d_addr_i   <= addr;
        d_be_i     <= be;
        d_wdata_i  <= wdata;
        @(posedge clk_i);
        d_strobe_i <= 1'b0;
        lat = 1;
        @(negedge clk_i);
        while (!d_ready_o) begin
            @(negedge clk_i);
            lat++;
        end
        rdata = d_rdata_o;
        if (on_chip) begin
            check_value("d_ready_o latency", 32'd1, 32'(lat));
        end else begin
            // Ready passes straight through from the responder
            check_value("d_ready_o latency", 32'(req_delay), 32'(lat));
        end
    endtask

    // ----------------------------------------
    // External port responder
    // ----------------------------------------
    initial begin
        logic [ADDR_W-1:0] cap_addr;
        dev_ready_i <= 1'b0;
        dev_rdata_i <= '0;
        forever begin
            @(negedge clk_i);
            if (rst_n_i && dev_strobe_o) begin
                cap_addr = dev_addr_o;
                check_true(req_addr[SEG_MSB:SEG_LSB] != SEG_TCM &&
                           req_addr[SEG_MSB:SEG_LSB] != SEG_CLINT,
                           "external strobe for an on-chip address");
                check_value("dev_addr_o", req_addr, dev_addr_o);
                check_bit("dev_rw_o", req_rw, dev_rw_o);
                check_value("dev_be_o", 32'(req_be), 32'(dev_be_o));
                check_value("dev_wdata_o", req_wdata, dev_wdata_o);
                // Variable latency picked by the host side
                repeat (req_delay) @(posedge clk_i);
                dev_ready_i <= 1'b1;
                dev_rdata_i <= ext_value(cap_addr);
                @(posedge clk_i);
                dev_ready_i <= 1'b0;
                dev_rdata_i <= '0;
            end
        end
    end

    // Response compare with one expectation per ready pulse
    always @(negedge clk_i) begin
        logic [DATA_W-1:0] exp_v;
        bit                chk;
        if (rst_n_i && d_ready_o) begin
            if (exp_q.size() == 0) begin
                check_true(1'b0, "d_ready_o pulsed with no request outstanding");
            end else begin
                exp_v = exp_q.pop_front();
                chk   = chk_q.pop_front();
                if (chk) begin
                    check_value("d_rdata_o", exp_v, d_rdata_o);
                end
            end
        end
    end

    // Run limit
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("Timeout: run still busy after %0d cycles", cycle_cnt);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] prev;
        logic [ADDR_W-1:0] addr;
        logic [BE_W-1:0]   be_r;
        logic [DATA_W-1:0] wd_r;
        logic              rw;
        int                base;
        int                start;
        int                kind;
        int unsigned       w;
        void'($urandom(SEED));
        rst_n_i    <= 1'b0;
        d_strobe_i <= 1'b0;
        d_rw_i     <= 1'b0;
        d_addr_i   <= '0;
        d_be_i     <= '0;
        d_wdata_i  <= '0;
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);

        // Outputs quiet after reset
        check_bit("d_ready_o", 1'b0, d_ready_o);
        check_bit("dev_strobe_o", 1'b0, dev_strobe_o);
        check_bit("tmr_irq_o", 1'b0, tmr_irq_o);
        check_bit("sft_irq_o", 1'b0, sft_irq_o);
        report_test("reset_state");

        // Full TCM window fill followed by partial writes and a readback
        base = int'($urandom_range(0, TCM_WORDS - TCM_WIN));
        for (int i = 0; i < TCM_WIN; i++) begin
            addr = tcm_addr(base + i);
            bus_access(1'b1, addr, '1, fill_word(addr), rd);
        end
        for (int i = 0; i < TCM_WRS; i++) begin
            be_r = BE_W'($urandom);
            wd_r = $urandom;
            addr = tcm_addr(base + int'($urandom_range(0, TCM_WIN - 1)));
            bus_access(1'b1, addr, be_r, wd_r, rd);
        end
        for (int i = 0; i < TCM_WIN; i++) begin
            bus_access(1'b0, tcm_addr(base + i), '0, '0, rd);
        end
        report_test("tcm_write_read");

        // External port pass-through and variable latency
        for (int i = 0; i < EXT_COUNT; i++) begin
            rw   = 1'($urandom_range(0, 1));
            be_r = BE_W'($urandom);
            wd_r = $urandom;
            bus_access(rw, ext_addr(), be_r, wd_r, rd);
        end
        report_test("external_port");

        // Software interrupt set and clear
        bus_access(1'b1, clint_addr(CLINT_MSIP), '1, 32'h1, rd);
        @(posedge clk_i);
        @(negedge clk_i);
        check_bit("sft_irq_o", 1'b1, sft_irq_o);
        bus_access(1'b0, clint_addr(CLINT_MSIP), '0, '0, rd);
        bus_access(1'b1, clint_addr(CLINT_MSIP), '1, 32'h0, rd);
        @(posedge clk_i);
        @(negedge clk_i);
        check_bit("sft_irq_o", 1'b0, sft_irq_o);
        bus_access(1'b0, clint_addr(CLINT_MSIP), '0, '0, rd);
        report_test("software_irq");

        // Clear mtime and set compare to 20 then poll for the timer interrupt
        bus_access(1'b1, clint_addr(CLINT_MTIME_LO), '1, '0, rd);
        bus_access(1'b1, clint_addr(CLINT_MTIME_HI), '1, '0, rd);
        start = cycle_cnt;
        bus_access(1'b1, clint_addr(CLINT_CMP_LO), '1, 32'd20, rd);
        bus_access(1'b1, clint_addr(CLINT_CMP_HI), '1, '0, rd);
        check_bit("tmr_irq_o", 1'b0, tmr_irq_o);
        prev = '0;
        while (!tmr_irq_o && (cycle_cnt - start) <= IRQ_LIMIT) begin
            bus_access(1'b0, clint_addr(CLINT_MTIME_LO), '0, '0, rd);
            check_true(rd >= prev, "mtime read went backwards");
            prev = rd;
        end
        check_true(tmr_irq_o && (cycle_cnt - start) <= IRQ_LIMIT,
                   "tmr_irq_o did not rise before the deadline");
        bus_access(1'b1, clint_addr(CLINT_CMP_LO), '1, '1, rd);
        bus_access(1'b1, clint_addr(CLINT_CMP_HI), '1, '1, rd);
        @(posedge clk_i);
        @(negedge clk_i);
        check_bit("tmr_irq_o", 1'b0, tmr_irq_o);
        bus_access(1'b0, clint_addr(CLINT_CMP_HI), '0, '0, rd);
        report_test("timer_irq");

        // Mixed targets check the response steering of the registered select
        for (int i = 0; i < MIX_COUNT; i++) begin
            kind = int'($urandom_range(0, 2));
            rw   = 1'($urandom_range(0, 1));
            be_r = BE_W'($urandom);
            wd_r = $urandom;
            if (kind == 0) begin
                addr = tcm_addr(base + int'($urandom_range(0, TCM_WIN - 1)));
                bus_access(rw, addr, be_r, wd_r, rd);
            end else if (kind == 1) begin
                w = $urandom_range(0, 7);
                // Time base stays untouched here
                if (w == CLINT_MTIME_LO || w == CLINT_MTIME_HI) begin
                    rw = 1'b0;
                end
                bus_access(rw, clint_addr(w), '1, wd_r, rd);
            end else begin
                bus_access(rw, ext_addr(), be_r, wd_r, rd);
            end
        end
        report_test("mixed_targets");

        repeat (2) @(posedge clk_i);
        check_true(exp_q.size() == 0, "responses still outstanding at the end");
        $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
